/* audio_fir_top.sv */
`timescale 1ns/1ps

module audio_fir_top #(
  parameter int NUM_TAPS = 8,  // power of 2
  parameter int DATA_W   = 16,
  parameter int BCLK_DIV = 4   // even
) (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             adc_sdata_i,
  input  logic                             cfg_req_i,
  input  logic                             cfg_we_i,
  input  logic [audio_pkg::CFG_ADDR_W-1:0] cfg_addr_i,
  input  logic [DATA_W-1:0]                cfg_wdata_i,
  output logic                             bclk_o,
  output logic                             lrclk_o,
  output logic                             dac_sdata_o,
  output logic                             cfg_ack_o,
  output logic [DATA_W-1:0]                cfg_rdata_o
);

  localparam int IDX_W = $clog2(NUM_TAPS);

  // codec side
  logic              rx_valid;
  logic [DATA_W-1:0] rx_sample;
  logic              res_valid;
  logic [DATA_W-1:0] res_sample;

  // coefficient config
  logic                             coef_we;
  logic [audio_pkg::CFG_ADDR_W-1:0] coef_addr;
  logic [DATA_W-1:0]                coef_wdata;
  logic [DATA_W-1:0]                coef_rd_data;

  // datapath sequencing
  logic              buf_we;
  logic [IDX_W-1:0]  tap_idx;
  logic              acc_clr;
  logic              acc_en;
  logic              acc_last;
  logic              bypass;
  logic [DATA_W-1:0] tap_sample;
  logic [DATA_W-1:0] tap_coef;

  codec_serdes #(
    .DATA_W   (DATA_W),
    .BCLK_DIV (BCLK_DIV)
  ) i_codec_serdes (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .adc_sdata_i  (adc_sdata_i),
    .res_valid_i  (res_valid),
    .res_sample_i (res_sample),
    .bclk_o       (bclk_o),
    .lrclk_o      (lrclk_o),
    .dac_sdata_o  (dac_sdata_o),
    .rx_valid_o   (rx_valid),
    .rx_sample_o  (rx_sample)
  );

  fir_ctrl #(
    .NUM_TAPS (NUM_TAPS),
    .DATA_W   (DATA_W)
  ) i_fir_ctrl (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .cfg_req_i      (cfg_req_i),
    .cfg_we_i       (cfg_we_i),
    .cfg_addr_i     (cfg_addr_i),
    .cfg_wdata_i    (cfg_wdata_i),
    .rx_valid_i     (rx_valid),
    .coef_rd_data_i (coef_rd_data),
    .cfg_ack_o      (cfg_ack_o),
    .cfg_rdata_o    (cfg_rdata_o),
    .coef_we_o      (coef_we),
    .coef_addr_o    (coef_addr),
    .coef_wdata_o   (coef_wdata),
    .buf_we_o       (buf_we),
    .tap_idx_o      (tap_idx),
    .acc_clr_o      (acc_clr),
    .acc_en_o       (acc_en),
    .acc_last_o     (acc_last),
    .bypass_o       (bypass),
    .res_valid_o    (res_valid)
  );

  fir_sample_buf #(
    .NUM_TAPS (NUM_TAPS),
    .DATA_W   (DATA_W)
  ) i_fir_sample_buf (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .we_i      (buf_we),
    .sample_i  (rx_sample),
    .tap_idx_i (tap_idx),
    .sample_o  (tap_sample)
  );

  fir_coef_mem #(
    .NUM_TAPS (NUM_TAPS),
    .DATA_W   (DATA_W)
  ) i_fir_coef_mem (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .we_i      (coef_we),
    .wr_addr_i (coef_addr),
    .wdata_i   (coef_wdata),
    .tap_idx_i (tap_idx),
    .coef_o    (tap_coef),
    .rd_data_o (coef_rd_data)
  );

  fir_mac #(
    .NUM_TAPS (NUM_TAPS),
    .DATA_W   (DATA_W)
  ) i_fir_mac (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .sample_i   (tap_sample),
    .coef_i     (tap_coef),
    .acc_clr_i  (acc_clr),
    .acc_en_i   (acc_en),
    .acc_last_i (acc_last),
    .bypass_i   (bypass),
    .result_o   (res_sample)
  );

endmodule

/* audio_pkg.sv */
package audio_pkg;

  // control FSM of the filter path
  typedef enum logic [2:0] {
    S_IDLE    = 3'd0, // waiting for a sample or a config request
    S_CFG_ACK = 3'd1, // config access done, ack goes out
    S_LOAD    = 3'd2, // first tap read issued, accumulator cleared
    S_MAC     = 3'd3, // one product per cycle
    S_DRAIN   = 3'd4, // last product lands in the accumulator
    S_DONE    = 3'd5  // result register valid
  } fir_state_e;

  // configuration address map
  // coefficients sit at 0 .. NUM_TAPS-1
  localparam int CFG_ADDR_W = 6;
  localparam logic [CFG_ADDR_W-1:0] CTRL_ADDR = 6'h20;
  localparam int CTRL_EN_BIT = 0; // filter enable in the control register

  // q1.15 coefficients, 16'h7fff is just below one
  localparam int COEF_FRAC = 15;

endpackage

/* codec_serdes.sv */
`timescale 1ns/1ps

module codec_serdes #(
  parameter int DATA_W   = 16,
  parameter int BCLK_DIV = 4
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              adc_sdata_i,
  input  logic              res_valid_i,
  input  logic [DATA_W-1:0] res_sample_i,
  output logic              bclk_o,
  output logic              lrclk_o,
  output logic              dac_sdata_o,
  output logic              rx_valid_o,
  output logic [DATA_W-1:0] rx_sample_o
);

  localparam int DIV_W = (BCLK_DIV > 2) ? $clog2(BCLK_DIV) : 1;
  localparam int BIT_W = $clog2(2 * DATA_W);

  logic [DIV_W-1:0]  div_cnt_q;
  logic [BIT_W-1:0]  bit_cnt_q;
  logic [BIT_W-1:0]  bit_cnt_nxt;
  logic              rise_tick;
  logic              fall_tick;
  logic              bit_last;
  logic              frame_start;
  logic [DATA_W-1:0] rx_shift_q;
  logic [DATA_W-1:0] tx_shift_q;
  logic [DATA_W-1:0] hold_q;

  // bclk is low for the first half of each divider period
  assign rise_tick = (div_cnt_q == DIV_W'(BCLK_DIV / 2 - 1));
  assign fall_tick = (div_cnt_q == DIV_W'(BCLK_DIV - 1));

  assign bit_last    = (bit_cnt_q == BIT_W'(2 * DATA_W - 1));
  assign bit_cnt_nxt = bit_last ? '0 : bit_cnt_q + 1'b1;
  assign frame_start = fall_tick && bit_last; // falling lrclk, left slot begins

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      div_cnt_q  <= '0;
      bit_cnt_q  <= '0;
      bclk_o     <= 1'b0;
      lrclk_o    <= 1'b0;
      rx_valid_o <= 1'b0;
      tx_shift_q <= '0;
      hold_q     <= '0;
    end else begin
      div_cnt_q <= fall_tick ? '0 : div_cnt_q + 1'b1;

      if (rise_tick) begin
        bclk_o <= 1'b1;
      end else if (fall_tick) begin
        bclk_o <= 1'b0;
      end

      if (fall_tick) begin
        bit_cnt_q <= bit_cnt_nxt;
        lrclk_o   <= (bit_cnt_nxt >= BIT_W'(DATA_W)); // high in the right slot
      end

      // last left bit already sampled, lrclk goes high on this edge
      rx_valid_o <= fall_tick && (bit_cnt_q == BIT_W'(DATA_W - 1));

      if (res_valid_i) begin
        hold_q <= res_sample_i;
      end

      // msb leaves with the lrclk edge, zeros fill the right slot
      if (frame_start) begin
        tx_shift_q <= hold_q;
      end else if (fall_tick) begin
        tx_shift_q <= {tx_shift_q[DATA_W-2:0], 1'b0};
      end
    end
  end

  // left word only, right slot ignored
  always_ff @(posedge clk_i) begin
    if (rise_tick && !lrclk_o) begin
      rx_shift_q <= {rx_shift_q[DATA_W-2:0], adc_sdata_i};
    end
  end

  assign rx_sample_o = rx_shift_q; // stable until the next left slot
  assign dac_sdata_o = tx_shift_q[DATA_W-1];

  rx_valid_pulse_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) rx_valid_o |=> !rx_valid_o
  ) else $error("rx_valid held longer than one cycle");

endmodule

/* compile.f */
audio_pkg.sv
codec_serdes.sv
fir_ctrl.sv
fir_sample_buf.sv
fir_coef_mem.sv
fir_mac.sv
audio_fir_top.sv
tb_audio_fir.sv

/* fir_coef_mem.sv */
`timescale 1ns/1ps

module fir_coef_mem #(
  parameter int NUM_TAPS = 8,
  parameter int DATA_W   = 16
) (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             we_i,
  input  logic [audio_pkg::CFG_ADDR_W-1:0] wr_addr_i,
  input  logic [DATA_W-1:0]                wdata_i,
  input  logic [$clog2(NUM_TAPS)-1:0]      tap_idx_i,
  output logic [DATA_W-1:0]                coef_o,
  output logic [DATA_W-1:0]                rd_data_o
);

  localparam int IDX_W = $clog2(NUM_TAPS);

  logic [DATA_W-1:0] coef_q [NUM_TAPS];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_TAPS; i++) begin
        coef_q[i] <= '0;
      end
      coef_o <= '0;
    end else begin
      if (we_i) begin
        coef_q[wr_addr_i[IDX_W-1:0]] <= wdata_i;
      end
      coef_o <= coef_q[tap_idx_i]; // aligned with the sample buffer read
    end
  end

  // read-back, zero outside the coefficient range
  assign rd_data_o = (wr_addr_i < audio_pkg::CFG_ADDR_W'(NUM_TAPS)) ?
                     coef_q[wr_addr_i[IDX_W-1:0]] : '0;

endmodule

/* fir_ctrl.sv */
`timescale 1ns/1ps

module fir_ctrl #(
  parameter int NUM_TAPS = 8,
  parameter int DATA_W   = 16
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              cfg_req_i,
  input  logic                              cfg_we_i,
  input  logic [audio_pkg::CFG_ADDR_W-1:0]  cfg_addr_i,
  input  logic [DATA_W-1:0]                 cfg_wdata_i,
  input  logic                              rx_valid_i,
  input  logic [DATA_W-1:0]                 coef_rd_data_i,
  output logic                              cfg_ack_o,
  output logic [DATA_W-1:0]                 cfg_rdata_o,
  output logic                              coef_we_o,
  output logic [audio_pkg::CFG_ADDR_W-1:0]  coef_addr_o,
  output logic [DATA_W-1:0]                 coef_wdata_o,
  output logic                              buf_we_o,
  output logic [$clog2(NUM_TAPS)-1:0]       tap_idx_o,
  output logic                              acc_clr_o,
  output logic                              acc_en_o,
  output logic                              acc_last_o,
  output logic                              bypass_o,
  output logic                              res_valid_o
);

  localparam int IDX_W = $clog2(NUM_TAPS);

  audio_pkg::fir_state_e state_q;
  audio_pkg::fir_state_e state_d;

  logic [IDX_W-1:0]  tap_q;
  logic              enable_q;
  logic              ack_q;
  logic [DATA_W-1:0] rdata_q;
  logic              run_start;
  logic              cfg_start;
  logic              cfg_hit_coef;
  logic              cfg_hit_ctrl;

  // a sample always wins over a pending config request
  assign run_start = rx_valid_i &&
                     (state_q == audio_pkg::S_IDLE || state_q == audio_pkg::S_CFG_ACK);
  assign cfg_start = cfg_req_i && !ack_q && !rx_valid_i && (state_q == audio_pkg::S_IDLE);

  assign cfg_hit_coef = (cfg_addr_i < audio_pkg::CFG_ADDR_W'(NUM_TAPS));
  assign cfg_hit_ctrl = (cfg_addr_i == audio_pkg::CTRL_ADDR);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      audio_pkg::S_IDLE: begin
        if (run_start) begin
          state_d = audio_pkg::S_LOAD;
        end else if (cfg_start) begin
          state_d = audio_pkg::S_CFG_ACK;
        end
      end
      audio_pkg::S_CFG_ACK: state_d = run_start ? audio_pkg::S_LOAD : audio_pkg::S_IDLE;
      audio_pkg::S_LOAD:    state_d = audio_pkg::S_MAC;
      audio_pkg::S_MAC: begin
        if (tap_q == '0) begin // index wrapped, last product
          state_d = audio_pkg::S_DRAIN;
        end
      end
      audio_pkg::S_DRAIN:   state_d = audio_pkg::S_DONE;
      audio_pkg::S_DONE:    state_d = audio_pkg::S_IDLE;
      default:              state_d = audio_pkg::S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= audio_pkg::S_IDLE;
      tap_q    <= '0;
      enable_q <= 1'b0;
      ack_q    <= 1'b0;
      rdata_q  <= '0;
    end else begin
      state_q <= state_d;

      if (run_start) begin
        tap_q <= '0;
      end else if (state_q == audio_pkg::S_LOAD || state_q == audio_pkg::S_MAC) begin
        tap_q <= tap_q + 1'b1;
      end

      // read data captured before a write lands
      if (cfg_start) begin
        rdata_q <= cfg_hit_ctrl ? {{(DATA_W-1){1'b0}}, enable_q} : coef_rd_data_i;
        if (cfg_we_i && cfg_hit_ctrl) begin
          enable_q <= cfg_wdata_i[audio_pkg::CTRL_EN_BIT];
        end
      end

      if (state_q == audio_pkg::S_CFG_ACK) begin
        ack_q <= 1'b1;
      end else if (!cfg_req_i) begin
        ack_q <= 1'b0; // four-phase return to zero
      end
    end
  end

  assign cfg_ack_o    = ack_q;
  assign cfg_rdata_o  = rdata_q;
  assign coef_we_o    = cfg_start && cfg_we_i && cfg_hit_coef;
  assign coef_addr_o  = cfg_addr_i;
  assign coef_wdata_o = cfg_wdata_i;

  assign buf_we_o    = run_start;
  assign tap_idx_o   = tap_q;
  assign acc_clr_o   = (state_q == audio_pkg::S_LOAD);
  assign acc_en_o    = (state_q == audio_pkg::S_MAC);
  assign acc_last_o  = (state_q == audio_pkg::S_MAC) && (tap_q == '0);
  assign bypass_o    = !enable_q;
  assign res_valid_o = (state_q == audio_pkg::S_DONE);

  ack_needs_req_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) $rose(cfg_ack_o) |-> cfg_req_i
  ) else $error("cfg_ack rose while cfg_req was low");

  // a frame is far longer than one run
  rx_outside_run_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    rx_valid_i |-> (state_q inside {audio_pkg::S_IDLE, audio_pkg::S_CFG_ACK})
  ) else $error("sample arrived during a filter run");

endmodule

/* fir_mac.sv */
`timescale 1ns/1ps

module fir_mac #(
  parameter int NUM_TAPS = 8,
  parameter int DATA_W   = 16
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic [DATA_W-1:0] sample_i,
  input  logic [DATA_W-1:0] coef_i,
  input  logic              acc_clr_i,
  input  logic              acc_en_i,
  input  logic              acc_last_i,
  input  logic              bypass_i,
  output logic [DATA_W-1:0] result_o
);

  // headroom for NUM_TAPS full-scale products
  localparam int ACC_W = 2 * DATA_W + $clog2(NUM_TAPS);

  logic signed [2*DATA_W-1:0] prod;
  logic signed [ACC_W-1:0]    acc_q;
  logic signed [ACC_W-1:0]    acc_shift;
  logic [DATA_W-1:0]          sat_val;
  logic [DATA_W-1:0]          tap0_q;
  logic                       first_q;
  logic                       last_q;
  logic                       ovf;

  assign prod      = $signed(sample_i) * $signed(coef_i);
  assign acc_shift = acc_q >>> audio_pkg::COEF_FRAC;
  assign ovf       = (acc_shift[ACC_W-1:DATA_W-1] != {(ACC_W-DATA_W+1){acc_shift[ACC_W-1]}});

  always_comb begin
    if (!ovf) begin
      sat_val = acc_shift[DATA_W-1:0];
    end else if (acc_shift[ACC_W-1]) begin
      sat_val = {1'b1, {(DATA_W-1){1'b0}}}; // clip negative
    end else begin
      sat_val = {1'b0, {(DATA_W-1){1'b1}}};
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      first_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      first_q <= acc_clr_i; // tap 0 data arrives the cycle after clear
      last_q  <= acc_last_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (acc_clr_i) begin
      acc_q <= '0;
    end else if (acc_en_i) begin
      acc_q <= acc_q + prod;
    end
    if (first_q) begin
      tap0_q <= sample_i;
    end
    if (last_q) begin
      result_o <= bypass_i ? tap0_q : sat_val;
    end
  end

  clr_en_excl_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) !(acc_en_i && acc_clr_i)
  ) else $error("accumulator cleared and enabled together");

endmodule

/* fir_sample_buf.sv */
`timescale 1ns/1ps

module fir_sample_buf #(
  parameter int NUM_TAPS = 8,
  parameter int DATA_W   = 16
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        we_i,
  input  logic [DATA_W-1:0]           sample_i,
  input  logic [$clog2(NUM_TAPS)-1:0] tap_idx_i,
  output logic [DATA_W-1:0]           sample_o
);

  localparam int IDX_W = $clog2(NUM_TAPS);

  logic [DATA_W-1:0] hist_q [NUM_TAPS];
  logic [IDX_W-1:0]  wr_ptr_q;
  logic [IDX_W-1:0]  rd_ptr;

  // newest entry sits just behind the write pointer, wraps for free
  assign rd_ptr = wr_ptr_q - tap_idx_i - 1'b1;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_TAPS; i++) begin
        hist_q[i] <= '0;
      end
      wr_ptr_q <= '0;
      sample_o <= '0;
    end else begin
      if (we_i) begin
        hist_q[wr_ptr_q] <= sample_i;
        wr_ptr_q         <= wr_ptr_q + 1'b1;
      end
      sample_o <= hist_q[rd_ptr]; // one cycle read latency
    end
  end

endmodule

/* run.sh */
#!/bin/sh
# build and run the audio FIR testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_audio_fir -f compile.f -o sim_tb_audio_fir

# the simulator exits non-zero on a failure, keep the log for the search below
./obj_dir/sim_tb_audio_fir > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log; then
  exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
  exit 1
fi
exit 0

/* tb_audio_fir.sv */
`timescale 1ns/1ps

module tb_audio_fir;

  localparam int NUM_TAPS  = 8;
  localparam int DATA_W    = 16;
  localparam int BCLK_DIV  = 4;
  localparam int FRAME_CYC = 2 * DATA_W * BCLK_DIV;
  localparam int MAX_CYC   = 9000; // about 60 frames plus config traffic

  logic                             clk_i = 1'b0;
  logic                             rst_n_i;
  logic                             adc_sdata_i;
  logic                             cfg_req_i;
  logic                             cfg_we_i;
  logic [audio_pkg::CFG_ADDR_W-1:0] cfg_addr_i;
  logic [DATA_W-1:0]                cfg_wdata_i;
  logic                             bclk_o;
  logic                             lrclk_o;
  logic                             dac_sdata_o;
  logic                             cfg_ack_o;
  logic [DATA_W-1:0]                cfg_rdata_o;

  // reference model state
  logic [DATA_W-1:0] hist_sh [NUM_TAPS];
  logic [DATA_W-1:0] coef_sh [NUM_TAPS];
  logic              en_sh;
  logic [DATA_W-1:0] exp_word;
  logic              exp_valid;
  logic              cfg_busy;

  // codec model state
  logic [DATA_W-1:0] next_word;
  logic [DATA_W-1:0] cur_word;
  logic [DATA_W-1:0] dac_word;
  logic [DATA_W-1:0] dac_last;
  logic              bclk_prev;
  logic              lrclk_prev;
  int                bit_pos;
  int                rx_count;
  int                cycle_cnt;
  int                last_rise_cyc;
  logic [31:0]       lcg_state;

  audio_fir_top #(
    .NUM_TAPS (NUM_TAPS),
    .DATA_W   (DATA_W),
    .BCLK_DIV (BCLK_DIV)
  ) i_audio_fir_top (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .adc_sdata_i (adc_sdata_i),
    .cfg_req_i   (cfg_req_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .bclk_o      (bclk_o),
    .lrclk_o     (lrclk_o),
    .dac_sdata_o (dac_sdata_o),
    .cfg_ack_o   (cfg_ack_o),
    .cfg_rdata_o (cfg_rdata_o)
  );

  always #20 clk_i = ~clk_i;

  task automatic report_error(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    $display("TEST FAIL");
    $fatal(1, "stopped at first error");
  endtask

  function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[30:15];
  endfunction

  // shifted and saturated sum of products or the newest sample when bypassed
  function automatic logic [DATA_W-1:0] model_out();
    longint acc;
    acc = 0;
    if (!en_sh) begin
      return hist_sh[0];
    end
    for (int t = 0; t < NUM_TAPS; t++) begin
      acc += longint'($signed(hist_sh[t])) * longint'($signed(coef_sh[t]));
    end
    acc = acc >>> audio_pkg::COEF_FRAC;
    if (acc > 32767) begin
      return 16'h7fff;
    end else if (acc < -32768) begin
      return 16'h8000;
    end
    return acc[DATA_W-1:0];
  endfunction

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYC) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYC);
      $display("TEST FAIL");
      $fatal(1, "cycle limit reached");
    end
  end

  // codec master model moves everything on the falling clk edge
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      if (lrclk_prev && !lrclk_o) begin // msb goes out as the left slot begins
        cur_word    = next_word;
        bit_pos     = DATA_W - 1;
        adc_sdata_i <= cur_word[bit_pos];
      end else if (bclk_prev && !bclk_o && !lrclk_o && bit_pos > 0) begin
        bit_pos     = bit_pos - 1;
        adc_sdata_i <= cur_word[bit_pos];
      end
      if (!bclk_prev && bclk_o) begin
        if (!lrclk_o) begin
          dac_word = {dac_word[DATA_W-2:0], dac_sdata_o};
        end else begin
          right_zero_chk: assert (dac_sdata_o == 1'b0)
            else report_error("right slot DAC bit is not zero");
        end
      end
      if (!lrclk_prev && lrclk_o) begin // left word complete both ways
        if (last_rise_cyc >= 0) begin
          frame_rate_chk: assert (cycle_cnt - last_rise_cyc == FRAME_CYC)
            else report_error($sformatf("frame length %0d cycles",
                                        cycle_cnt - last_rise_cyc));
        end
        last_rise_cyc = cycle_cnt;
        if (exp_valid) begin
          dac_model_chk: assert (dac_word == exp_word)
            else report_error($sformatf("dac word %h, expected %h", dac_word, exp_word));
        end
        dac_last = dac_word;
        for (int t = NUM_TAPS - 1; t > 0; t--) begin
          hist_sh[t] = hist_sh[t-1];
        end
        hist_sh[0] = cur_word;
        exp_word   = model_out();
        exp_valid  = !cfg_busy; // skipped when config races the run
        rx_count   = rx_count + 1;
      end
      bclk_prev  = bclk_o;
      lrclk_prev = lrclk_o;
    end
  end

  ack_rise_chk: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) $rose(cfg_ack_o) |-> cfg_req_i
  ) else report_error("cfg_ack rose without cfg_req");

  ack_fall_chk: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) cfg_ack_o && cfg_req_i |=> cfg_ack_o
  ) else report_error("cfg_ack fell while cfg_req still high");

  // one four-phase access with the shadow state following the write
  task automatic cfg_access(input logic we, input logic [5:0] addr,
                            input logic [15:0] wdata, output logic [15:0] rdata);
    cfg_busy = 1'b1;
    @(negedge clk_i);
    cfg_req_i   <= 1'b1;
    cfg_we_i    <= we;
    cfg_addr_i  <= addr;
    cfg_wdata_i <= wdata;
    do @(negedge clk_i); while (!cfg_ack_o);
    rdata = cfg_rdata_o;
    @(negedge clk_i); // req stays up a cycle longer while ack holds
    cfg_req_i <= 1'b0;
    do @(negedge clk_i); while (cfg_ack_o);
    if (we && addr < NUM_TAPS) begin
      coef_sh[addr] = wdata;
    end else if (we && addr == audio_pkg::CTRL_ADDR) begin
      en_sh = wdata[0];
    end
    cfg_busy = 1'b0;
  endtask

  task automatic write_read(input logic [5:0] addr, input logic [15:0] wdata,
                            input logic [15:0] expect_rd);
    logic [15:0] rd;
    cfg_access(1'b1, addr, wdata, rd);
    cfg_access(1'b0, addr, 16'h0, rd);
    readback_chk: assert (rd == expect_rd)
      else report_error($sformatf("addr %h read %h, expected %h", addr, rd, expect_rd));
  endtask

  task automatic wait_frames(input int n);
    int target;
    target = rx_count + n;
    wait (rx_count >= target);
  endtask

  initial begin
    logic [15:0] rd;
    rst_n_i       = 1'b0;
    adc_sdata_i   = 1'b0;
    cfg_req_i     = 1'b0;
    cfg_we_i      = 1'b0;
    cfg_addr_i    = '0;
    cfg_wdata_i   = '0;
    en_sh         = 1'b0;
    exp_word      = '0;
    exp_valid     = 1'b0;
    cfg_busy      = 1'b0;
    next_word     = '0;
    cur_word      = '0;
    dac_word      = '0;
    dac_last      = '0;
    bclk_prev     = 1'b0;
    lrclk_prev    = 1'b0;
    bit_pos       = 0;
    rx_count      = 0;
    cycle_cnt     = 0;
    last_rise_cyc = -1;
    lcg_state     = 32'h7a33;
    for (int t = 0; t < NUM_TAPS; t++) begin
      hist_sh[t] = '0;
      coef_sh[t] = '0;
    end
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    // reset values read back as zero
    for (int a = 0; a < NUM_TAPS; a++) begin
      cfg_access(1'b0, 6'(a), 16'h0, rd);
      reset_coef_chk: assert (rd == 16'h0)
        else report_error($sformatf("coef %0d not zero after reset", a));
    end
    cfg_access(1'b0, audio_pkg::CTRL_ADDR, 16'h0, rd);
    reset_ctrl_chk: assert (rd == 16'h0)
      else report_error("control register not zero after reset");

    // scaled lcg coefficients while the history is still all zeros
    for (int a = 0; a < NUM_TAPS; a++) begin
      rd = lcg_next();
      rd = $unsigned($signed(rd) >>> 3);
      write_read(6'(a), rd, rd);
    end
    write_read(6'h10, 16'hbeef, 16'h0); // unmapped
    write_read(6'h3f, 16'h1234, 16'h0);
    write_read(audio_pkg::CTRL_ADDR, 16'h0001, 16'h0001);

    // impulse response in tap order
    wait_frames(1);
    for (int j = 0; j <= NUM_TAPS; j++) begin
      next_word = (j == 0) ? 16'h4000 : 16'h0;
      wait_frames(1);
      if (j > 0) begin
        impulse_chk: assert (dac_last == $unsigned($signed(coef_sh[j-1]) >>> 1))
          else report_error($sformatf("impulse tap %0d gave %h", j - 1, dac_last));
      end
    end

    // random audio against the model
    for (int f = 0; f < 30; f++) begin
      next_word = lcg_next();
      wait_frames(1);
    end

    // bypass passes last frame's input through
    cfg_access(1'b1, audio_pkg::CTRL_ADDR, 16'h0000, rd);
    wait_frames(1);
    for (int f = 0; f < 4; f++) begin
      next_word = lcg_next();
      wait_frames(1);
    end

    // saturation both ways
    for (int a = 0; a < NUM_TAPS; a++) begin
      cfg_access(1'b1, 6'(a), 16'h7fff, rd);
    end
    cfg_access(1'b1, audio_pkg::CTRL_ADDR, 16'h0001, rd);
    for (int f = 0; f < 8; f++) begin
      next_word = 16'h7fff;
      wait_frames(1);
    end
    sat_pos_chk: assert (dac_last == 16'h7fff)
      else report_error($sformatf("positive clip gave %h", dac_last));
    for (int f = 0; f < 8; f++) begin
      next_word = 16'h8000;
      wait_frames(1);
    end
    sat_neg_chk: assert (dac_last == 16'h8000)
      else report_error($sformatf("negative clip gave %h", dac_last));

    $display("TEST PASS");
    $finish;
  end

endmodule
